//--- hdl/memCtrlPkg.sv
package memCtrlPkg;

  // Store data word width
  localparam int dataWidth = 32;

  // Word address, 256-word RAM
  localparam int addrWidth = 8;

  // Store access ports on the circuit side
  localparam int numStores = 2;

  // Control channels announcing store counts
  localparam int numControls = 2;
  localparam int ctrlWidth = 32;

  // Pending-store counter size
  localparam int pendWidth = 16;

endpackage

//--- hdl/ctrlFsmPkg.sv
package ctrlFsmPkg;

  // Handshake sequencing for one block of stores
  // stIdle waits for start, stRun waits for "no more requests",
  // stDrain waits for outstanding stores, stDone offers end
  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stRun   = 2'd1,
    stDrain = 2'd2,
    stDone  = 2'd3
  } ctrlState;

endpackage

//--- hdl/storeArbiter.sv
module storeArbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  // Flat per-port request vectors with port 0 in the low slice
  input  logic [memCtrlPkg::numStores*memCtrlPkg::addrWidth-1:0] reqAddr,
  input  logic [memCtrlPkg::numStores*memCtrlPkg::dataWidth-1:0] reqData,
  input  logic [memCtrlPkg::numStores-1:0]                     reqAddrValid,
  input  logic [memCtrlPkg::numStores-1:0]                     reqDataValid,
  // One-hot acceptance that drives both ready signals of the port
  output logic [memCtrlPkg::numStores-1:0]                     grant,
  // Registered write toward the RAM
  output logic                                                 storeEn,
  output logic [memCtrlPkg::addrWidth-1:0]                     storeAddr,
  output logic [memCtrlPkg::dataWidth-1:0]                     storeData
);
  import memCtrlPkg::*;

  logic [numStores-1:0] completeReq;
  logic [addrWidth-1:0] selAddr;
  logic [dataWidth-1:0] selData;

  // A port competes only with address and data both present
  assign completeReq = reqAddrValid & reqDataValid;

  // Lowest set bit wins under fixed priority
  assign grant = completeReq & (~completeReq + numStores'(1));

  // Pick the winning slice
  always_comb begin
    selAddr = '0;
    selData = '0;
    for (int i = 0; i < numStores; i++) begin
      if (grant[i]) begin
        selAddr = reqAddr[i*addrWidth +: addrWidth];
        selData = reqData[i*dataWidth +: dataWidth];
      end
    end
  end

  // Write strobe follows the grant by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      storeEn <= 1'b0;
    end else begin
      storeEn <= |grant;
    end
  end

  // Payload only loads on an accepted request
  always_ff @(posedge clk) begin
    if (|grant) begin
      storeAddr <= selAddr;
      storeData <= selData;
    end
  end

  // At most one port accepted per cycle
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  );

endmodule

//--- hdl/pendingStoreCounter.sv
module pendingStoreCounter (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic [memCtrlPkg::numControls*memCtrlPkg::ctrlWidth-1:0] ctrl,
  input  logic [memCtrlPkg::numControls-1:0]                       ctrlValid,
  input  logic                                                      storeEn,
  output logic                                                      allRequestsDone
);
  import memCtrlPkg::*;

  logic [pendWidth-1:0] count;
  logic [pendWidth-1:0] tokenSum;

  // Add up every token arriving this cycle
  // Only the low bits of a token count, the counter is narrower
  always_comb begin
    tokenSum = '0;
    for (int i = 0; i < numControls; i++) begin
      if (ctrlValid[i]) begin
        tokenSum = tokenSum + ctrl[i*ctrlWidth +: pendWidth];
      end
    end
  end

  // Tokens and a write in the same cycle both apply
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count + tokenSum - {{(pendWidth-1){1'b0}}, storeEn};
    end
  end

  // Done only with nothing pending and nothing being announced
  assign allRequestsDone = (count == '0) && (ctrlValid == '0);

  // A write must have been announced, or be announced right now
  storeAnnounced: assert property (
    @(posedge clk) disable iff (rst)
    storeEn |-> (count != '0 || ctrlValid != '0)
  );

endmodule

//--- hdl/memCtrlFsm.sv
module memCtrlFsm (
  input  logic clk,
  input  logic rst,
  // Start handshake
  input  logic memStartValid,
  output logic memStartReady,
  // No-more-requests handshake
  input  logic ctrlEndValid,
  output logic ctrlEndReady,
  // End handshake
  output logic memEndValid,
  input  logic memEndReady,
  // From the pending-store counter
  input  logic allRequestsDone
);
  import ctrlFsmPkg::*;

  ctrlState state;
  ctrlState nextState;

  always_comb begin
    nextState = state;
    unique case (state)
      stIdle:  if (memStartValid) nextState = stRun;
      stRun:   if (ctrlEndValid) nextState = stDrain;
      // Wait for the last announced store to be written
      stDrain: if (allRequestsDone) nextState = stDone;
      stDone:  if (memEndReady) nextState = stIdle;
      default: nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      state <= nextState;
    end
  end

  // Ready and valid outputs decode straight from the state
  assign memStartReady = (state == stIdle);
  assign ctrlEndReady  = (state == stRun);
  assign memEndValid   = (state == stDone);

  // End is offered until taken
  endHeld: assert property (
    @(posedge clk) disable iff (rst)
    (memEndValid && !memEndReady) |=> memEndValid
  );

endmodule

//--- hdl/storeController.sv
module storeController (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic                                                      memStartValid,
  output logic                                                      memStartReady,
  output logic                                                      memEndValid,
  input  logic                                                      memEndReady,
  input  logic                                                      ctrlEndValid,
  output logic                                                      ctrlEndReady,
  // Control tokens, ready is always high
  input  logic [memCtrlPkg::numControls*memCtrlPkg::ctrlWidth-1:0] ctrl,
  input  logic [memCtrlPkg::numControls-1:0]                       ctrlValid,
  // Store access ports
  input  logic [memCtrlPkg::numStores*memCtrlPkg::addrWidth-1:0]   stAddr,
  input  logic [memCtrlPkg::numStores-1:0]                         stAddrValid,
  output logic [memCtrlPkg::numStores-1:0]                         stAddrReady,
  input  logic [memCtrlPkg::numStores*memCtrlPkg::dataWidth-1:0]   stData,
  input  logic [memCtrlPkg::numStores-1:0]                         stDataValid,
  output logic [memCtrlPkg::numStores-1:0]                         stDataReady,
  // Write port toward the RAM
  output logic                                                      storeEn,
  output logic [memCtrlPkg::addrWidth-1:0]                         storeAddr,
  output logic [memCtrlPkg::dataWidth-1:0]                         storeData
);
  import memCtrlPkg::*;

  logic [numStores-1:0] grant;
  logic                 allRequestsDone;

  storeArbiter arbiter (
    .clk         (clk),
    .rst         (rst),
    .reqAddr     (stAddr),
    .reqData     (stData),
    .reqAddrValid(stAddrValid),
    .reqDataValid(stDataValid),
    .grant       (grant),
    .storeEn     (storeEn),
    .storeAddr   (storeAddr),
    .storeData   (storeData)
  );

  // Address and data of a port are taken together
  assign stAddrReady = grant;
  assign stDataReady = grant;

  pendingStoreCounter counter (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .ctrlValid      (ctrlValid),
    .storeEn        (storeEn),
    .allRequestsDone(allRequestsDone)
  );

  memCtrlFsm control (
    .clk            (clk),
    .rst            (rst),
    .memStartValid  (memStartValid),
    .memStartReady  (memStartReady),
    .ctrlEndValid   (ctrlEndValid),
    .ctrlEndReady   (ctrlEndReady),
    .memEndValid    (memEndValid),
    .memEndReady    (memEndReady),
    .allRequestsDone(allRequestsDone)
  );

endmodule

//--- hdl/dualPortBram.sv
module dualPortBram (
  input  logic                            clk,
  // Write port, from the store controller
  input  logic                            wrEn,
  input  logic [memCtrlPkg::addrWidth-1:0] wrAddr,
  input  logic [memCtrlPkg::dataWidth-1:0] wrData,
  // Read port, one cycle latency
  input  logic                            rdEn,
  input  logic [memCtrlPkg::addrWidth-1:0] rdAddr,
  output logic [memCtrlPkg::dataWidth-1:0] rdData
);
  import memCtrlPkg::*;

  // Full address space
  logic [dataWidth-1:0] mem [2**addrWidth];

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Same-edge read of a written word returns the old contents
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

//--- hdl/memSubsystem.sv
module memSubsystem (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic                                                      memStartValid,
  output logic                                                      memStartReady,
  output logic                                                      memEndValid,
  input  logic                                                      memEndReady,
  input  logic                                                      ctrlEndValid,
  output logic                                                      ctrlEndReady,
  input  logic [memCtrlPkg::numControls*memCtrlPkg::ctrlWidth-1:0] ctrl,
  input  logic [memCtrlPkg::numControls-1:0]                       ctrlValid,
  input  logic [memCtrlPkg::numStores*memCtrlPkg::addrWidth-1:0]   stAddr,
  input  logic [memCtrlPkg::numStores-1:0]                         stAddrValid,
  output logic [memCtrlPkg::numStores-1:0]                         stAddrReady,
  input  logic [memCtrlPkg::numStores*memCtrlPkg::dataWidth-1:0]   stData,
  input  logic [memCtrlPkg::numStores-1:0]                         stDataValid,
  output logic [memCtrlPkg::numStores-1:0]                         stDataReady,
  // Second RAM port, for inspection
  input  logic                                                      rdEn,
  input  logic [memCtrlPkg::addrWidth-1:0]                         rdAddr,
  output logic [memCtrlPkg::dataWidth-1:0]                         rdData
);
  import memCtrlPkg::*;

  // Registered write from controller to RAM
  logic                 storeEn;
  logic [addrWidth-1:0] storeAddr;
  logic [dataWidth-1:0] storeData;

  storeController controller (
    .clk          (clk),
    .rst          (rst),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .storeEn      (storeEn),
    .storeAddr    (storeAddr),
    .storeData    (storeData)
  );

  dualPortBram bram (
    .clk   (clk),
    .wrEn  (storeEn),
    .wrAddr(storeAddr),
    .wrData(storeData),
    .rdEn  (rdEn),
    .rdAddr(rdAddr),
    .rdData(rdData)
  );

endmodule

//--- verif/memSubsystemTb.sv
module memSubsystemTb;
  timeunit 1ns;
  timeprecision 1ps;

  import memCtrlPkg::*;

  // Test lengths and timing
  localparam int clkPeriod = 20;
  localparam int resetCycles = 10;
  localparam int numRandStores = 40;
  localparam int maxSessionStores = 12;
  localparam int totalStores = numRandStores + 4 + maxSessionStores;
  // About 10 cycles per store plus reset, handshakes and the final sweep
  localparam int watchdogCycles = totalStores * 10 + 600;

  logic clk;
  logic rst;
  logic memStartValid, memStartReady, memEndValid, memEndReady;
  logic ctrlEndValid, ctrlEndReady;
  logic [numControls*ctrlWidth-1:0] ctrl;
  logic [numControls-1:0] ctrlValid;
  logic [numStores*addrWidth-1:0] stAddr;
  logic [numStores-1:0] stAddrValid, stAddrReady, stDataValid, stDataReady;
  logic [numStores*dataWidth-1:0] stData;
  logic rdEn;
  logic [addrWidth-1:0] rdAddr;
  logic [dataWidth-1:0] rdData;

  // Shadow copy of the RAM that the compare process fills
  logic [dataWidth-1:0] shadow [2**addrWidth];
  logic written [2**addrWidth];
  logic [31:0] lcgState;
  logic sessionArmed;
  int sessionAccepts;
  int sessionTarget;

  memSubsystem dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Use the upper LCG bits since the low ones repeat quickly
  function automatic int randBelow(int limit);
    return int'((nextRand() >> 16) % 32'(limit));
  endfunction

  // Expected winner among complete requests or -1 when there is none
  function automatic int winningPort(logic [numStores-1:0] complete);
    int win;
    win = -1;
    // Port 0 has the highest priority
    for (int p = numStores - 1; p >= 0; p--) begin
      if (complete[p]) win = p;
    end
    return win;
  endfunction

  task automatic abortRun();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkEqual(logic [31:0] actual, logic [31:0] expected, string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      abortRun();
    end
  endtask

  // A drive slot is 2 ns after a rising edge
  task automatic nextDriveSlot();
    @(posedge clk);
    #2;
  endtask

  // Token values reach the pending counter in one cycle
  task automatic announce(int n0, int n1);
    ctrl[0 +: ctrlWidth] = ctrlWidth'(n0);
    ctrl[ctrlWidth +: ctrlWidth] = ctrlWidth'(n1);
    ctrlValid = '1;
    nextDriveSlot();
    ctrlValid = '0;
  endtask

  task automatic storeWord(int port, logic [addrWidth-1:0] addr, logic [dataWidth-1:0] data);
    stAddr[port*addrWidth +: addrWidth] = addr;
    stData[port*dataWidth +: dataWidth] = data;
    stAddrValid[port] = 1'b1;
    stDataValid[port] = 1'b1;
    @(posedge clk);
    while (!stAddrReady[port]) @(posedge clk);
    #2;
    stAddrValid[port] = 1'b0;
    stDataValid[port] = 1'b0;
  endtask

  task automatic readWord(logic [addrWidth-1:0] addr, output logic [dataWidth-1:0] word);
    rdEn = 1'b1;
    rdAddr = addr;
    nextDriveSlot();
    word = rdData;
    rdEn = 1'b0;
  endtask

  // Compare process checks grants against fixed priority and updates the shadow
  always @(posedge clk) begin
    int win;
    logic [numStores-1:0] expGrant;
    logic [addrWidth-1:0] a;
    if (!rst) begin
      win = winningPort(stAddrValid & stDataValid);
      expGrant = '0;
      if (win >= 0) expGrant[win] = 1'b1;
      checkEqual(32'(stAddrReady), 32'(expGrant), "address ready against fixed priority");
      checkEqual(32'(stDataReady), 32'(expGrant), "data ready against fixed priority");
      if (win >= 0) begin
        a = stAddr[win*addrWidth +: addrWidth];
        shadow[a] = stData[win*dataWidth +: dataWidth];
        written[a] = 1'b1;
        if (sessionArmed) sessionAccepts++;
      end
    end
  end

  // End must not be offered before the last announced store
  always @(negedge clk) begin
    if (sessionArmed && sessionAccepts < sessionTarget) begin
      checkEqual(32'(memEndValid), 32'h0, "end offered before all stores were accepted");
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
    abortRun();
  end

  initial begin
    logic [dataWidth-1:0] word;
    logic [dataWidth-1:0] d1;
    logic [addrWidth-1:0] addr;
    int n;
    int n0;
    rst = 1'b1;
    {memStartValid, memEndReady, ctrlEndValid, rdEn} = '0;
    {ctrl, ctrlValid, stAddr, stAddrValid, stData, stDataValid, rdAddr} = '0;
    lcgState = 32'h98bc_1d20;
    {sessionArmed, sessionAccepts, sessionTarget} = '0;
    for (int a = 0; a < 2**addrWidth; a++) written[a] = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #2;
    rst = 1'b0;

    // Idle outputs right after reset
    @(negedge clk);
    checkEqual(32'(memStartReady), 32'h1, "start ready after reset");
    checkEqual(32'(memEndValid), 32'h0, "end valid after reset");
    checkEqual(32'(ctrlEndReady), 32'h0, "ctrl end ready after reset");
    nextDriveSlot();

    // Random stores on port 1 with each word read back once written
    announce(numRandStores, 0);
    for (int i = 0; i < numRandStores; i++) begin
      addr = addrWidth'(randBelow(2**addrWidth));
      storeWord(1, addr, nextRand());
      // RAM write lands one edge after storeEn
      nextDriveSlot();
      readWord(addr, word);
      checkEqual(word, shadow[addr], "read-back after random store");
    end

    // Both ports complete on one address and port 0 goes first
    announce(2, 0);
    addr = addrWidth'(randBelow(2**addrWidth));
    d1 = nextRand();
    stAddr = {addr, addr};
    stData = {d1, nextRand()};
    stAddrValid = 2'b11;
    stDataValid = 2'b11;
    @(posedge clk);
    checkEqual(32'(stAddrReady), 32'h1, "only port 0 ready when both request");
    #2;
    stAddrValid = 2'b10;
    stDataValid = 2'b10;
    @(posedge clk);
    while (!stAddrReady[1]) @(posedge clk);
    #2;
    {stAddrValid, stDataValid} = '0;
    nextDriveSlot();
    readWord(addr, word);
    checkEqual(word, d1, "shared address holds port 1 data");

    // Address-only and data-only requests wait for their other half
    announce(1, 1);
    addr = addrWidth'(randBelow(2**addrWidth));
    stAddr = {addr ^ 8'h80, addr};
    stData = {nextRand(), nextRand()};
    stAddrValid = 2'b01;
    stDataValid = 2'b10;
    repeat (3) begin
      @(posedge clk);
      checkEqual(32'(stAddrReady | stDataReady), 32'h0, "incomplete request saw ready");
    end
    #2;
    stAddrValid = 2'b11;
    @(posedge clk);
    checkEqual(32'(stDataReady), 32'h2, "port 1 accepted once complete");
    #2;
    stAddrValid = 2'b01;
    stDataValid = 2'b01;
    @(posedge clk);
    checkEqual(32'(stAddrReady), 32'h1, "port 0 accepted once complete");
    #2;
    {stAddrValid, stDataValid} = '0;

    // Full session of start, tokens, no more requests, stores and end
    memStartValid = 1'b1;
    @(negedge clk);
    while (!memStartReady) @(negedge clk);
    nextDriveSlot();
    memStartValid = 1'b0;
    n = 4 + randBelow(maxSessionStores - 3);
    n0 = randBelow(n + 1);
    sessionAccepts = 0;
    sessionTarget = n;
    sessionArmed = 1'b1;
    announce(n0, n - n0);
    ctrlEndValid = 1'b1;
    @(negedge clk);
    while (!ctrlEndReady) @(negedge clk);
    nextDriveSlot();
    ctrlEndValid = 1'b0;
    for (int i = 0; i < n; i++) begin
      repeat (randBelow(4)) nextDriveSlot();
      storeWord(randBelow(2), addrWidth'(randBelow(2**addrWidth)), nextRand());
    end
    @(negedge clk);
    while (!memEndValid) @(negedge clk);
    // End stays offered while the acknowledge is held back
    repeat (1 + randBelow(6)) begin
      @(negedge clk);
      checkEqual(32'(memEndValid), 32'h1, "end dropped before acknowledge");
    end
    nextDriveSlot();
    memEndReady = 1'b1;
    nextDriveSlot();
    memEndReady = 1'b0;
    sessionArmed = 1'b0;
    @(negedge clk);
    checkEqual(32'(memStartReady), 32'h1, "start ready after end acknowledge");
    checkEqual(32'(memEndValid), 32'h0, "end valid after acknowledge");

    // Every written word against the shadow memory
    nextDriveSlot();
    for (int a = 0; a < 2**addrWidth; a++) begin
      if (written[a]) begin
        readWord(addrWidth'(a), word);
        checkEqual(word, shadow[a], "final memory sweep");
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- sim.f
hdl/memCtrlPkg.sv
hdl/ctrlFsmPkg.sv
hdl/storeArbiter.sv
hdl/pendingStoreCounter.sv
hdl/memCtrlFsm.sv
hdl/storeController.sv
hdl/dualPortBram.sv
hdl/memSubsystem.sv
verif/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module memSubsystemTb -o simv \
  && ./obj_dir/simv 2>&1 | tee sim.log
grep -q "PASS: all tests" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
